/* flist.f */
src/alpha_pkg.sv
src/button_edge_detect.sv
src/readout_sequencer.sv
src/serial_word_shifter.sv
src/bias_register_loader.sv
src/alpha_control_top.sv
verif/clock_gen.sv
verif/alpha_control_props.sv
verif/alpha_control_checker.sv
verif/alpha_control_tb.sv

/* Makefile */
SIM ?= verilator
TOP ?= alpha_control_tb
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS ?= --binary --timing --assert
PASS_TEXT ?= Simulation passed

.PHONY: lint sim clean

lint:
	$(SIM) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(SIM) $(SIM_FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)
	out=$$(./$(BUILD_DIR)/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* verif/alpha_control_tb.sv */
`timescale 1ns/100ps

module alpha_control_tb;

	localparam int PICKOFF = 6;
	localparam int TIMING = 10;
	localparam int ADC_TIME = 64;
	localparam int SERIAL = 3;
	localparam int HOLD = 10; // press length, cycles
	localparam int GAP_MAX = 64;
	localparam int READOUT_CYCLES = 11*TIMING + ADC_TIME + PICKOFF + 3;
	localparam int BIAS_CYCLES = alpha_pkg::BIAS_COUNT * (52*SERIAL + 2) + PICKOFF + 3;
	// restart test runs about one and a half readouts
	localparam int TIMEOUT_CYCLES = 4*READOUT_CYCLES + 2*BIAS_CYCLES + 6*(GAP_MAX + HOLD) + 200;

	logic clock, reset;
	logic readout_button, bias_button;
	alpha_pkg::asic_ctrl_t ctrl;
	alpha_pkg::serial_port_t serial;
	logic readout_active, bias_loading;
	int errors, checks;
	int cycle_count = 0;
	int offset;

	clock_gen #(.half_period(2), .reset_cycles(2)) clocks (.clock(clock), .reset(reset));

	alpha_control_top #(
		.pickoff_depth(PICKOFF), .timing_constant(TIMING),
		.adc_conversion_time(ADC_TIME), .serial_constant(SERIAL)
	) DUT (
		.clock(clock), .reset(reset), .readout_button(readout_button),
		.bias_button(bias_button), .ctrl(ctrl), .serial(serial),
		.readout_active(readout_active), .bias_loading(bias_loading)
	);

	alpha_control_checker #(
		.pickoff_depth(PICKOFF), .timing_constant(TIMING), .adc_conversion_time(ADC_TIME)
	) monitor (
		.clock(clock), .reset(reset), .readout_button(readout_button),
		.bias_button(bias_button), .ctrl(ctrl), .serial(serial),
		.readout_active(readout_active), .bias_loading(bias_loading),
		.errors(errors), .checks(checks)
	);

	task automatic press_button(input logic on_bias);
		@(posedge clock);
		if (on_bias) bias_button <= 1'b1;
		else readout_button <= 1'b1;
		repeat (HOLD) @(posedge clock);
		bias_button <= 1'b0;
		readout_button <= 1'b0;
	endtask

	task automatic idle_gap();
		int gap;
		gap = 16 + int'($urandom % (GAP_MAX - 16));
		repeat (gap) @(posedge clock);
	endtask

	task automatic wait_idle();
		while (readout_active || bias_loading) @(posedge clock);
	endtask

	initial begin
		void'($urandom(32'hd8e1)); // seeds the generator once
		readout_button = 1'b0;
		bias_button = 1'b0;
		while (reset !== 1'b0) @(posedge clock);
		idle_gap(); // outputs must stay low here
		press_button(1'b0); // single readout
		wait_idle();
		idle_gap();
		press_button(1'b0); // readout, restarted mid sequence
		while (!ctrl.sync) @(posedge clock);
		press_button(1'b0);
		wait_idle();
		idle_gap();
		press_button(1'b1); // bias load
		wait_idle();
		idle_gap();
		offset = int'($urandom % 4); // both buttons, a few cycles apart
		@(posedge clock);
		readout_button <= 1'b1;
		repeat (offset) @(posedge clock);
		bias_button <= 1'b1;
		repeat (HOLD) @(posedge clock);
		readout_button <= 1'b0;
		bias_button <= 1'b0;
		wait_idle();
		repeat (20) @(posedge clock);
		$display("checks %0d, errors %0d, assertion failures %0d",
			checks, errors, DUT.props.failures);
		if (errors == 0 && checks > 0 && DUT.props.failures == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("run timed out after %0d cycles", cycle_count);
			$display("checks %0d, errors %0d, assertion failures %0d",
				checks, errors, DUT.props.failures);
			$display("Simulation failed");
			$finish;
		end
	end

endmodule

/* verif/alpha_control_checker.sv */
`timescale 1ns/100ps

module alpha_control_checker #(
	parameter int pickoff_depth = 6,
	parameter int timing_constant = 10,
	parameter int adc_conversion_time = 64,
	parameter alpha_pkg::bias_values_t bias_values = alpha_pkg::DEFAULT_BIAS_VALUES
) (
	input logic clock,
	input logic reset,
	input logic readout_button,
	input logic bias_button,
	input alpha_pkg::asic_ctrl_t ctrl,
	input alpha_pkg::serial_port_t serial,
	input logic readout_active,
	input logic bias_loading,
	output int errors,
	output int checks
);

	localparam int T = timing_constant;
	localparam int A = adc_conversion_time;
	localparam int START_DELAY = pickoff_depth + 2; // first sample, pipeline, start reg
	localparam int WORD_BITS = alpha_pkg::BIAS_WORD_WIDTH;
	localparam int STREAM_BITS = alpha_pkg::BIAS_COUNT * WORD_BITS;

	// count of nth rise (even nth) or fall (odd nth), -1 when none
	// lines 0 dreset, 1 sync, 2 tok_a_f2t, 3 trig_top, 4 readout_active
	function automatic int expected_readout_edges(input int line, input int nth);
		int edges[5][4];
		edges = '{'{T + 1, 2*T + 1, -1, -1}, '{3*T + 1, 4*T + 1, -1, -1},
			'{5*T + 1, 6*T + 1, 9*T + A + 1, 10*T + A + 1},
			'{7*T + 1, 8*T + 1, -1, -1}, '{0, 11*T + A + 1, -1, -1}};
		return edges[line][nth];
	endfunction

	function automatic logic expected_level(input int line, input int count);
		logic level;
		level = 1'b0;
		for (int n = 0; n < 4; n += 2) begin
			if (expected_readout_edges(line, n) >= 0 && count >= expected_readout_edges(line, n)
					&& count < expected_readout_edges(line, n + 1)) begin
				level = 1'b1;
			end
		end
		return level;
	endfunction

	// word 0 first, each {pad, address, data} MSB first
	function automatic logic [STREAM_BITS-1:0] expected_bias_stream();
		logic [STREAM_BITS-1:0] stream;
		stream = '0;
		for (int i = 0; i < alpha_pkg::BIAS_COUNT; i++) begin
			stream = {stream[STREAM_BITS-WORD_BITS-1:0], 2'b00, 2'(i), bias_values[i]};
		end
		return stream;
	endfunction

	localparam logic [STREAM_BITS-1:0] BIAS_STREAM = expected_bias_stream();

	int cycle = 0; // edges seen
	int readout_pending, readout_c0, count, bias_pending;
	int bit_count, sclk_in_word, pclk_count;
	logic readout_button_q, bias_button_q, sclk_q, pclk_q, loading_q;
	alpha_pkg::asic_ctrl_t ctrl_exp;
	logic active_exp;

	initial begin
		errors = 0;
		checks = 0;
	end

	task automatic report_mismatch(input string msg);
		errors++;
		$display("FAIL at %0t: %s", $time, msg);
	endtask

	always @(posedge clock) cycle <= cycle + 1;

	// outputs sampled mid cycle, after the edge settled
	always @(negedge clock) begin
		if (reset) begin
			readout_pending = -1;
			readout_c0 = -1; // no sequence yet
			bias_pending = -1;
			{readout_button_q, bias_button_q, sclk_q, pclk_q, loading_q} = '0;
		end else begin
			if (readout_button && !readout_button_q) readout_pending = cycle + START_DELAY;
			if (bias_button && !bias_button_q) bias_pending = cycle + START_DELAY;
			if (cycle == readout_pending) readout_c0 = cycle; // count 0, restart too
			count = (readout_c0 >= 0) ? cycle - readout_c0 : -1;
			ctrl_exp = '{dreset: expected_level(0, count), sync: expected_level(1, count),
				tok_a_f2t: expected_level(2, count), trig_top: expected_level(3, count)};
			active_exp = expected_level(4, count);
			checks++;
			if (ctrl !== ctrl_exp || readout_active !== active_exp)
				report_mismatch($sformatf("count %0d ctrl %b active %b, expected %b %b",
					count, ctrl, readout_active, ctrl_exp, active_exp));
			if (bias_loading && !loading_q) begin
				checks++;
				if (cycle != bias_pending)
					report_mismatch($sformatf("bias_loading rose at %0d, expected %0d",
						cycle, bias_pending));
				bit_count = 0;
				sclk_in_word = 0;
				pclk_count = 0;
			end
			checks++;
			if (!bias_loading && serial !== '0)
				report_mismatch($sformatf("serial %b while idle", serial));
			if (serial.sclk && !sclk_q) begin // ASIC samples sin here
				checks++;
				if (bit_count >= STREAM_BITS)
					report_mismatch("sclk pulse past the last bias bit");
				else if (serial.sin !== BIAS_STREAM[STREAM_BITS-1-bit_count])
					report_mismatch($sformatf("bias bit %0d is %b", bit_count, serial.sin));
				bit_count++;
				sclk_in_word++;
			end
			if (serial.pclk && !pclk_q) begin
				checks++;
				if (sclk_in_word != WORD_BITS)
					report_mismatch($sformatf("pclk after %0d sclk pulses", sclk_in_word));
				sclk_in_word = 0;
				pclk_count++;
			end
			if (!bias_loading && loading_q) begin // load finished
				checks++;
				if (bit_count != STREAM_BITS || pclk_count != alpha_pkg::BIAS_COUNT)
					report_mismatch($sformatf("load ended with %0d bits, %0d pclk",
						bit_count, pclk_count));
			end
			readout_button_q = readout_button;
			bias_button_q = bias_button;
			sclk_q = serial.sclk;
			pclk_q = serial.pclk;
			loading_q = bias_loading;
		end
	end

endmodule

/* verif/alpha_control_props.sv */
`timescale 1ns/100ps

module alpha_control_props (
	input logic clock,
	input logic reset,
	input alpha_pkg::asic_ctrl_t ctrl,
	input alpha_pkg::serial_port_t serial,
	input logic readout_active,
	input logic bias_loading
);

	int failures = 0; // failed assertions so far

	// shift clock and parallel load never overlap
	sclk_pclk_apart: assert property (@(posedge clock) disable iff (reset)
		!(serial.sclk && serial.pclk))
		else begin
			failures++;
			$error("sclk and pclk high in the same cycle");
		end

	one_strobe: assert property (@(posedge clock) disable iff (reset)
		$countones({ctrl.dreset, ctrl.sync, ctrl.trig_top}) <= 1)
		else begin
			failures++;
			$error("more than one of dreset, sync, trig_top high");
		end

	ctrl_needs_active: assert property (@(posedge clock) disable iff (reset)
		(ctrl != '0) |-> readout_active)
		else begin
			failures++;
			$error("control line high with readout_active low");
		end

	serial_needs_loading: assert property (@(posedge clock) disable iff (reset)
		(serial != '0) |-> bias_loading)
		else begin
			failures++;
			$error("serial line high with bias_loading low");
		end

endmodule

bind alpha_control_top alpha_control_props props (
	.clock(clock),
	.reset(reset),
	.ctrl(ctrl),
	.serial(serial),
	.readout_active(readout_active),
	.bias_loading(bias_loading)
);

/* verif/clock_gen.sv */
`timescale 1ns/100ps

module clock_gen #(
	parameter int half_period = 2, // ns, 4 ns clock
	parameter int reset_cycles = 2
) (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #(half_period) clock = ~clock;
	end

	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clock);
		reset <= 1'b0; // released on an edge
	end

endmodule

/* src/alpha_control_top.sv */
`timescale 1ns/100ps

module alpha_control_top #(
	parameter int pickoff_depth = alpha_pkg::DEFAULT_PICKOFF,
	parameter int timing_constant = alpha_pkg::DEFAULT_TIMING_CONSTANT,
	parameter int adc_conversion_time = alpha_pkg::DEFAULT_ADC_CONVERSION_TIME,
	parameter int serial_constant = alpha_pkg::DEFAULT_SERIAL_CONSTANT,
	parameter alpha_pkg::bias_values_t bias_values = alpha_pkg::DEFAULT_BIAS_VALUES
) (
	input logic clock,
	input logic reset,
	input logic readout_button,
	input logic bias_button,
	output alpha_pkg::asic_ctrl_t ctrl,
	output alpha_pkg::serial_port_t serial,
	output logic readout_active, // status lamps
	output logic bias_loading
);

	logic readout_start;
	logic bias_start;

	button_edge_detect #(
		.pickoff_depth(pickoff_depth)
	) readout_button_edge (
		.clock(clock),
		.reset(reset),
		.button(readout_button),
		.start(readout_start)
	);

	button_edge_detect #(
		.pickoff_depth(pickoff_depth)
	) bias_button_edge (
		.clock(clock),
		.reset(reset),
		.button(bias_button),
		.start(bias_start)
	);

	readout_sequencer #(
		.timing_constant(timing_constant),
		.adc_conversion_time(adc_conversion_time)
	) sequencer (
		.clock(clock),
		.reset(reset),
		.start(readout_start),
		.ctrl(ctrl),
		.active(readout_active)
	);

	bias_register_loader #(
		.serial_constant(serial_constant),
		.bias_values(bias_values)
	) loader (
		.clock(clock),
		.reset(reset),
		.start(bias_start),
		.serial(serial),
		.loading(bias_loading)
	);

endmodule

/* src/bias_register_loader.sv */
`timescale 1ns/100ps

module bias_register_loader #(
	parameter int serial_constant = 5,
	parameter alpha_pkg::bias_values_t bias_values = alpha_pkg::DEFAULT_BIAS_VALUES
) (
	input logic clock,
	input logic reset,
	input logic start, // one cycle, restarts from word 0
	output alpha_pkg::serial_port_t serial,
	output logic loading
);

	localparam int DWELL_WIDTH = $clog2(2 * serial_constant + 1);
	localparam logic [DWELL_WIDTH-1:0] DWELL_PRE = DWELL_WIDTH'(2 * serial_constant - 1);
	localparam logic [DWELL_WIDTH-1:0] DWELL_STEP = DWELL_WIDTH'(serial_constant - 1);
	localparam logic [alpha_pkg::BIAS_ADDR_WIDTH-1:0] LAST_WORD =
		alpha_pkg::BIAS_ADDR_WIDTH'(alpha_pkg::BIAS_COUNT - 1);

	typedef enum logic [2:0] {
		LD_IDLE,
		LD_SHIFT, // word in the shifter
		LD_DRAIN, // restarted mid word, let it finish
		LD_PRE, // gap before pclk
		LD_PCLK, // pclk high
		LD_POST // gap before next word
	} load_state_t;

	load_state_t state;
	logic [alpha_pkg::BIAS_ADDR_WIDTH-1:0] word_idx;
	logic [DWELL_WIDTH-1:0] dwell;
	logic pclk;
	alpha_pkg::bias_word_t word;
	logic word_go;
	logic word_done;
	logic shift_sin;
	logic shift_sclk;
	logic in_flight;

	// address is the word index
	assign word = '{pad: '0, address: word_idx, data: bias_values[word_idx]};
	assign in_flight = (state == LD_SHIFT || state == LD_DRAIN) && !word_done;
	assign serial = '{sin: shift_sin, sclk: shift_sclk, pclk: pclk};

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= LD_IDLE;
			word_idx <= '0;
			dwell <= '0;
			pclk <= 1'b0;
			word_go <= 1'b0;
			loading <= 1'b0;
		end else begin
			word_go <= 1'b0;
			if (start) begin
				word_idx <= '0;
				pclk <= 1'b0;
				loading <= 1'b1;
				if (in_flight) begin
					state <= LD_DRAIN; // shifter has no abort
				end else begin
					word_go <= 1'b1;
					state <= LD_SHIFT;
				end
			end else begin
				case (state)
					LD_SHIFT: if (word_done) begin
						dwell <= DWELL_PRE;
						state <= LD_PRE;
					end
					LD_DRAIN: if (word_done) begin
						word_go <= 1'b1; // partial word never gets a pclk
						state <= LD_SHIFT;
					end
					LD_PRE: if (dwell != '0) begin
						dwell <= dwell - 1'b1;
					end else begin
						pclk <= 1'b1;
						dwell <= DWELL_STEP;
						state <= LD_PCLK;
					end
					LD_PCLK: if (dwell != '0) begin
						dwell <= dwell - 1'b1;
					end else begin
						pclk <= 1'b0;
						if (word_idx == LAST_WORD) begin
							loading <= 1'b0; // all four registers loaded
							state <= LD_IDLE;
						end else begin
							dwell <= DWELL_STEP;
							state <= LD_POST;
						end
					end
					LD_POST: if (dwell != '0) begin
						dwell <= dwell - 1'b1;
					end else begin
						word_idx <= word_idx + 1'b1;
						word_go <= 1'b1;
						state <= LD_SHIFT;
					end
					default: state <= LD_IDLE;
				endcase
			end
		end
	end

	serial_word_shifter #(
		.serial_constant(serial_constant)
	) shifter (
		.clock(clock),
		.reset(reset),
		.word(word),
		.go(word_go),
		.sin(shift_sin),
		.sclk(shift_sclk),
		.done(word_done)
	);

endmodule

/* src/serial_word_shifter.sv */
`timescale 1ns/100ps

module serial_word_shifter #(
	parameter int serial_constant = 5
) (
	input logic clock,
	input logic reset,
	input alpha_pkg::bias_word_t word,
	input logic go, // one cycle, only when idle
	output logic sin,
	output logic sclk,
	output logic done
);

	localparam int DWELL_WIDTH = $clog2(serial_constant + 1);
	localparam int BIT_WIDTH = $clog2(alpha_pkg::BIAS_WORD_WIDTH);
	localparam logic [DWELL_WIDTH-1:0] DWELL_STEP = DWELL_WIDTH'(serial_constant - 1);
	localparam logic [BIT_WIDTH-1:0] BIT_MSB = BIT_WIDTH'(alpha_pkg::BIAS_WORD_WIDTH - 1);

	alpha_pkg::bias_word_t word_q; // latched on go
	logic busy;
	logic [BIT_WIDTH-1:0] bit_idx;
	logic [1:0] sub; // 0 set data, 1 clock high, 2 clock low
	logic [DWELL_WIDTH-1:0] dwell;

	always_ff @(posedge clock) begin
		if (go) begin
			word_q <= word;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			bit_idx <= '0;
			sub <= '0;
			dwell <= '0;
			sin <= 1'b0;
			sclk <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (go) begin
				busy <= 1'b1;
				bit_idx <= BIT_MSB; // MSB first
				sub <= '0;
				dwell <= DWELL_STEP; // first step L cycles out
				sclk <= 1'b0;
			end else if (busy) begin
				if (dwell != '0) begin
					dwell <= dwell - 1'b1;
				end else begin
					dwell <= DWELL_STEP;
					case (sub)
						2'd0: begin
							sin <= word_q[bit_idx];
							sub <= 2'd1;
						end
						2'd1: begin
							sclk <= 1'b1; // ASIC samples sin here
							sub <= 2'd2;
						end
						2'd2: begin
							sclk <= 1'b0;
							sub <= 2'd0;
							if (bit_idx == '0) begin
								busy <= 1'b0;
								done <= 1'b1;
								sin <= 1'b0; // park data low between words
							end else begin
								bit_idx <= bit_idx - 1'b1;
							end
						end
						default: sub <= 2'd0;
					endcase
				end
			end
		end
	end

endmodule

/* src/readout_sequencer.sv */
`timescale 1ns/100ps

module readout_sequencer #(
	parameter int timing_constant = 100,
	parameter int adc_conversion_time = 8192
) (
	input logic clock,
	input logic reset,
	input logic start, // one cycle, restarts a running sequence
	output alpha_pkg::asic_ctrl_t ctrl,
	output logic active
);

	// longest dwell is trig_top low plus the conversion wait
	localparam int DWELL_WIDTH = $clog2(timing_constant + adc_conversion_time + 1);
	localparam logic [DWELL_WIDTH-1:0] DWELL_FIRST = DWELL_WIDTH'(timing_constant);
	localparam logic [DWELL_WIDTH-1:0] DWELL_PULSE = DWELL_WIDTH'(timing_constant - 1);
	localparam logic [DWELL_WIDTH-1:0] DWELL_ADC =
		DWELL_WIDTH'(timing_constant + adc_conversion_time - 1);

	logic [DWELL_WIDTH-1:0] dwell; // cycles left before next boundary
	logic [3:0] phase; // boundaries already passed

	always_ff @(posedge clock) begin
		if (reset) begin
			ctrl <= '0;
			active <= 1'b0;
			dwell <= '0;
			phase <= '0;
		end else if (start) begin
			// this edge is count 0
			ctrl <= '0;
			active <= 1'b1;
			dwell <= DWELL_FIRST; // first boundary at count T+1
			phase <= '0;
		end else if (active) begin
			if (dwell != '0) begin
				dwell <= dwell - 1'b1;
			end else begin
				dwell <= DWELL_PULSE; // most gaps are T
				phase <= phase + 1'b1;
				case (phase)
					4'd0: ctrl.dreset <= 1'b1;
					4'd1: ctrl.dreset <= 1'b0;
					4'd2: ctrl.sync <= 1'b1;
					4'd3: ctrl.sync <= 1'b0;
					4'd4: ctrl.tok_a_f2t <= 1'b1;
					4'd5: ctrl.tok_a_f2t <= 1'b0;
					4'd6: ctrl.trig_top <= 1'b1;
					4'd7: begin
						ctrl.trig_top <= 1'b0;
						dwell <= DWELL_ADC; // wait out the conversion
					end
					4'd8: ctrl.tok_a_f2t <= 1'b1; // second token, readout
					4'd9: ctrl.tok_a_f2t <= 1'b0;
					default: begin
						active <= 1'b0; // count 11T+A+1, done
						phase <= '0;
					end
				endcase
			end
		end
	end

endmodule

/* src/button_edge_detect.sv */
`timescale 1ns/100ps

module button_edge_detect #(
	parameter int pickoff_depth = 6
) (
	input logic clock,
	input logic reset,
	input logic button, // raw, not synchronized
	output logic start
);

	// newest sample at bit 0
	logic [pickoff_depth:0] pipeline;

	always_ff @(posedge clock) begin
		if (reset) begin
			pipeline <= '0;
			start <= 1'b0;
		end else begin
			pipeline <= {pipeline[pickoff_depth-1:0], button};
			// low then high at the two oldest taps
			start <= (pipeline[pickoff_depth:pickoff_depth-1] == 2'b01);
		end
	end

endmodule

/* src/alpha_pkg.sv */
package alpha_pkg;

	// legacy serial bias word layout
	localparam int BIAS_DATA_WIDTH = 12;
	localparam int BIAS_ADDR_WIDTH = 2;
	localparam int BIAS_WORD_WIDTH = 16;
	localparam int BIAS_PAD_WIDTH = BIAS_WORD_WIDTH - BIAS_ADDR_WIDTH - BIAS_DATA_WIDTH;
	localparam int BIAS_COUNT = 4; // CMPbias, ISEL, SBbias, DBbias

	// default timing, in clock cycles
	localparam int DEFAULT_TIMING_CONSTANT = 100; // width of each readout pulse
	localparam int DEFAULT_ADC_CONVERSION_TIME = 8192;
	localparam int DEFAULT_SERIAL_CONSTANT = 5; // cycles per serial step
	localparam int DEFAULT_PICKOFF = 6; // button pipeline tap

	// one 16 bit word on the serial port, pad goes out first
	typedef struct packed {
		logic [BIAS_PAD_WIDTH-1:0] pad; // always zero
		logic [BIAS_ADDR_WIDTH-1:0] address;
		logic [BIAS_DATA_WIDTH-1:0] data;
	} bias_word_t;

	// entry i is the value for address i
	typedef logic [BIAS_COUNT-1:0][BIAS_DATA_WIDTH-1:0] bias_values_t;

	localparam bias_values_t DEFAULT_BIAS_VALUES = {
		12'h4ff, // DBbias, address 3
		12'h3ff, // SBbias, address 2
		12'h5ff, // ISEL, address 1
		12'h1ff  // CMPbias, address 0
	};

	// readout control lines toward the ASIC
	typedef struct packed {
		logic dreset;
		logic sync;
		logic tok_a_f2t;
		logic trig_top;
	} asic_ctrl_t;

	// legacy serial port
	typedef struct packed {
		logic sin; // serial data
		logic sclk; // shift clock
		logic pclk; // parallel load
	} serial_port_t;

endpackage
